// ==== dv/tm1638_checker.sv ====
// bus monitor for the TM1638 driver testbench that decodes strobe groups and compares them
`timescale 1ns/1ps

module tm1638_checker import tm1638_pkg::*; #(
    parameter int FRAME_CLKS = 4000
) (
    input logic       clk,
    input logic       n_rst,
    input disp_in_t   disp_i,
    input tm_bus_t    bus_i,
    input logic [7:0] keys_i,
    input logic       frame_req_i
);

    logic [IMAGE_BYTES-1:0][7:0] exp_image;
    logic [7:0] grp_bytes [0:IMAGE_BYTES];
    logic [7:0] shreg;
    logic       prev_sclk;
    logic       prev_stb;
    logic       prev_frame;
    logic       frame_seen;
    logic       key_pending;
    int         grp_idx;
    int         grp_len;
    int         bit_cnt;
    int         cycle;
    int         last_frame;
    int         frames_done;
    int         check_cnt;
    int         err_cnt;

    // expected display image from the latched inputs
    function automatic logic [IMAGE_BYTES-1:0][7:0] ref_image(input disp_in_t d);
        logic [IMAGE_BYTES-1:0][7:0] img;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            img[2*i][7]   = d.dots[i];
            img[2*i][6:0] = d.suppress[i] ? 7'd0 : (seg_encode(d.hex[i]) | d.direct[i]);
            img[2*i+1]    = {7'd0, d.leds[i]};
        end
        return img;
    endfunction

    task check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %s: got 0x%h expected 0x%h", what, got, exp);
        end
    endtask

    task note_error(input string msg);
        err_cnt++;
        $display("ERROR: %s", msg);
    endtask

    task close_group();
        int exp_len;
        case (grp_idx)
            0:       exp_len = 1;
            1:       exp_len = 1 + IMAGE_BYTES;
            2:       exp_len = 1;
            default: exp_len = 1 + NUM_KEY_BYTES;
        endcase
        check_cnt++;
        if (grp_idx > 3) begin
            note_error($sformatf("strobe group %0d is one too many in the frame", grp_idx));
        end else if (grp_len != exp_len) begin
            note_error($sformatf("strobe group %0d carried %0d bytes instead of %0d",
                                 grp_idx, grp_len, exp_len));
        end else begin
            case (grp_idx)
                0: check_byte("bus_o.dio write command", grp_bytes[0], CMD_WRITE_AUTO);
                1: begin
                    check_byte("bus_o.dio address command", grp_bytes[0], CMD_ADDR0);
                    for (int i = 0; i < IMAGE_BYTES; i++) begin
                        check_byte($sformatf("bus_o.dio image byte %0d", i),
                                   grp_bytes[i+1], exp_image[i]);
                    end
                end
                2: check_byte("bus_o.dio display command", grp_bytes[0], CMD_DISPLAY_ON);
                default: check_byte("bus_o.dio read command", grp_bytes[0], CMD_READ_KEYS);
            endcase
        end
        if (grp_idx == 3) begin
            key_pending = 1'b1;   // keys_o settles one clock later
        end
        grp_idx++;
    endtask

    always @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            prev_sclk   = 1'b1;
            prev_stb    = 1'b1;
            prev_frame  = 1'b0;
            frame_seen  = 1'b0;
            key_pending = 1'b0;
            shreg       = '0;
            grp_idx     = 0;
            grp_len     = 0;
            bit_cnt     = 0;
            cycle       = 0;
            last_frame  = 0;
            frames_done = 0;
            check_cnt   = 0;
            err_cnt     = 0;
        end else begin
            cycle++;
            if (frame_req_i) begin
                if (prev_frame) begin
                    note_error("frame_req_o stayed high for more than one clock");
                end else begin
                    if (frame_seen) begin
                        check_cnt++;
                        if (cycle - last_frame != FRAME_CLKS) begin
                            err_cnt++;
                            $display("FAIL frame_req_o period: got 0x%h expected 0x%h",
                                     cycle - last_frame, FRAME_CLKS);
                        end
                    end
                    last_frame = cycle;
                    frame_seen = 1'b1;
                    exp_image  = ref_image(disp_i);
                    grp_idx    = 0;
                    grp_len    = 0;
                    bit_cnt    = 0;
                end
            end else if (!frame_seen) begin
                check_byte("bus_o after reset", {4'h0, bus_i}, 8'h0C); // sclk and stb high
                check_byte("keys_o after reset", keys_i, 8'h00);
            end
            if (key_pending) begin
                key_pending = 1'b0;
                check_byte("keys_o", keys_i, tm1638_tb.key_pat);
                frames_done++;
            end
            if (!bus_i.stb && bus_i.sclk && !prev_sclk) begin
                if (grp_idx < 3 || (grp_idx == 3 && grp_len == 0)) begin
                    check_cnt++;
                    if (!bus_i.dio_oe) begin
                        note_error("dio_oe was low while the driver was sending");
                    end
                end
                shreg = {bus_i.dio, shreg[7:1]};    // lsb first
                bit_cnt++;
                if (bit_cnt == 8) begin
                    bit_cnt = 0;
                    if (grp_len <= IMAGE_BYTES) begin
                        grp_bytes[grp_len] = shreg;
                    end
                    grp_len++;
                end
            end
            if (bus_i.stb && !prev_stb && frame_seen) begin
                close_group();
            end
            if (!bus_i.stb && prev_stb) begin
                grp_len = 0;
                bit_cnt = 0;
            end
            prev_sclk  = bus_i.sclk;
            prev_stb   = bus_i.stb;
            prev_frame = frame_req_i;
        end
    end

endmodule

// ==== dv/tm1638_tb.sv ====
// testbench top for the TM1638 driver with clock, reset, random display stimulus and board key model
`timescale 1ns/1ps

module tm1638_tb import tm1638_pkg::*; ();

    localparam int          CLK_HZ      = 8_000_000;
    localparam int          SCLK_HZ     = 1_000_000;
    localparam int          FRAME_HZ    = 2000;
    localparam int          FRAME_CLKS  = 4000;
    localparam int          NUM_FRAMES  = 3;
    localparam int          CYCLE_LIMIT = 4 * FRAME_CLKS + 100; // reset plus four frame periods
    localparam logic [31:0] SEED        = 32'h817de8de;

    logic       clk;
    logic       n_rst;
    disp_in_t   disp_i;
    logic       dio_i;
    tm_bus_t    bus;
    logic [7:0] keys;
    logic       frame_req;

    logic [31:0] lfsr_state;
    logic [7:0]  key_pat;       // pressed keys the board reports this frame
    int          rd_bits;       // serial clocks seen since dio was handed over
    logic        sclk_seen;
    logic        frame_req_q;   // frame request seen at the previous falling edge
    int          cycles;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic load_display();
        logic [31:0] r;
        disp_in_t    d;
        take_bits(32, r);
        d.hex = r;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            take_bits(21, r);
            d.direct[i] = r[6:0] & r[13:7] & r[20:14]; // sparse extra segments
        end
        take_bits(8, r);
        d.dots = r[7:0];
        take_bits(8, r);
        d.leds = r[7:0];
        take_bits(16, r);
        for (int i = 0; i < NUM_DIGITS; i++) begin
            d.suppress[i] = r[2*i] & r[2*i+1];    // about one in four
        end
        disp_i = d;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // new stimulus after each frame request, and the board side of dio
    always @(negedge clk) begin : board_and_stimulus
        logic [31:0] r;
        int          k;
        int          b;
        if (n_rst) begin
            if (frame_req_q) begin
                load_display();     // latched at the next frame request
                take_bits(8, r);
                key_pat = r[7:0];
            end
            frame_req_q = frame_req;
            if (bus.dio_oe) begin
                rd_bits = 0;
            end else if (bus.sclk && !sclk_seen) begin
                rd_bits++;
            end
            if (!bus.dio_oe && !bus.sclk && !bus.stb) begin
                k = rd_bits / 8;
                b = rd_bits % 8;
                take_bits(1, r);
                if (b == 0 && k < NUM_KEY_BYTES) begin
                    dio_i = key_pat[7-2*k];
                end else if (b == 4 && k < NUM_KEY_BYTES) begin
                    dio_i = key_pat[6-2*k];
                end else begin
                    dio_i = r[0];
                end
            end
            sclk_seen = bus.sclk;
        end
    end

    tm1638_drv #(
        .CLK_HZ   (CLK_HZ),
        .SCLK_HZ  (SCLK_HZ),
        .FRAME_HZ (FRAME_HZ)
    ) DUT (
        .clk         (clk),
        .n_rst       (n_rst),
        .disp_i      (disp_i),
        .dio_i       (dio_i),
        .bus_o       (bus),
        .keys_o      (keys),
        .frame_req_o (frame_req)
    );

    tm1638_checker #(
        .FRAME_CLKS (FRAME_CLKS)
    ) u_checker (
        .clk         (clk),
        .n_rst       (n_rst),
        .disp_i      (disp_i),
        .bus_i       (bus),
        .keys_i      (keys),
        .frame_req_i (frame_req)
    );

    initial begin
        n_rst       = 1'b0;
        dio_i       = 1'b0;
        key_pat     = '0;
        rd_bits     = 0;
        sclk_seen   = 1'b1;
        frame_req_q = 1'b0;
        cycles      = 0;
        lfsr_state  = SEED;
        load_display();
        repeat (4) @(negedge clk);
        n_rst = 1'b1;
        while (u_checker.frames_done < NUM_FRAMES && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d of %0d frames checked",
                     cycles, u_checker.frames_done, NUM_FRAMES);
        end
        $display("checks %0d, errors %0d", u_checker.check_cnt, u_checker.err_cnt);
        if (u_checker.err_cnt == 0 && cycles < CYCLE_LIMIT) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hdl/tm1638_pkg.sv
hdl/tm1638_tick_gen.sv
hdl/tm1638_frame_seq.sv
hdl/tm1638_display_image.sv
hdl/tm1638_serial_port.sv
hdl/tm1638_drv.sv
dv/tm1638_checker.sv
dv/tm1638_tb.sv

// ==== hdl/tm1638_display_image.sv ====
// latches the display inputs at each frame request and serves the 16 image bytes by address
`timescale 1ns/1ps

module tm1638_display_image import tm1638_pkg::*; (
    input  logic       clk,
    input  logic       n_rst,
    input  logic       frame_i,
    input  disp_in_t   disp_i,
    input  logic [3:0] addr_i,
    output logic [7:0] byte_o
);

    logic [IMAGE_BYTES-1:0][7:0] image_q;
    seg_t [NUM_DIGITS-1:0]       digit_seg;

    // digit segments, blanked by suppress
    always_comb begin
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (disp_i.suppress[i]) begin
                digit_seg[i] = '0;
            end else begin
                digit_seg[i] = seg_encode(disp_i.hex[i]) | disp_i.direct[i];
            end
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            image_q <= '0;
        end else if (frame_i) begin
            for (int i = 0; i < NUM_DIGITS; i++) begin
                image_q[2*i]   <= {disp_i.dots[i], digit_seg[i]};  // grid byte
                image_q[2*i+1] <= {7'b0, disp_i.leds[i]};          // led in seg9
            end
        end
    end

    assign byte_o = image_q[addr_i];

endmodule

// ==== hdl/tm1638_drv.sv ====
// top level of the TM1638 LED and key board driver, connects ticks, sequencer, image and port
`timescale 1ns/1ps

module tm1638_drv import tm1638_pkg::*; #(
    parameter int CLK_HZ   = 8_000_000,
    parameter int SCLK_HZ  = 1_000_000,
    parameter int FRAME_HZ = 2000
) (
    input  logic       clk,
    input  logic       n_rst,
    input  disp_in_t   disp_i,
    input  logic       dio_i,
    output tm_bus_t    bus_o,
    output logic [7:0] keys_o,
    output logic       frame_req_o
);

    logic       rise;
    logic       fall;
    byte_kind_t kind;
    logic [4:0] byte_idx;
    logic [2:0] bit_idx;
    logic       shift;
    logic       load;
    logic       sclk_low;
    logic       stb;
    logic       oe;
    logic       read_done;
    logic [4:0] image_addr;
    logic [7:0] image_byte;

    assign image_addr = byte_idx - 5'd2;   // image starts after 40h and C0h

    tm1638_tick_gen #(
        .CLK_HZ   (CLK_HZ),
        .SCLK_HZ  (SCLK_HZ),
        .FRAME_HZ (FRAME_HZ)
    ) u_tick_gen (
        .clk     (clk),
        .n_rst   (n_rst),
        .rise_o  (rise),
        .fall_o  (fall),
        .frame_o (frame_req_o)
    );

    tm1638_frame_seq u_frame_seq (
        .clk         (clk),
        .n_rst       (n_rst),
        .rise_i      (rise),
        .fall_i      (fall),
        .frame_i     (frame_req_o),
        .kind_o      (kind),
        .byte_idx_o  (byte_idx),
        .bit_idx_o   (bit_idx),
        .shift_o     (shift),
        .load_o      (load),
        .sclk_low_o  (sclk_low),
        .stb_o       (stb),
        .oe_o        (oe),
        .read_done_o (read_done)
    );

    tm1638_display_image u_display_image (
        .clk     (clk),
        .n_rst   (n_rst),
        .frame_i (frame_req_o),
        .disp_i  (disp_i),
        .addr_i  (image_addr[3:0]),
        .byte_o  (image_byte)
    );

    tm1638_serial_port u_serial_port (
        .clk          (clk),
        .n_rst        (n_rst),
        .rise_i       (rise),
        .kind_i       (kind),
        .byte_idx_i   (byte_idx),
        .bit_idx_i    (bit_idx),
        .shift_i      (shift),
        .load_i       (load),
        .sclk_low_i   (sclk_low),
        .stb_i        (stb),
        .oe_i         (oe),
        .read_done_i  (read_done),
        .image_byte_i (image_byte),
        .dio_i        (dio_i),
        .bus_o        (bus_o),
        .keys_o       (keys_o)
    );

endmodule

// ==== hdl/tm1638_frame_seq.sv ====
// steps through the 24 bytes of a TM1638 frame and 8 bits per byte, drives strobe and clock gating
`timescale 1ns/1ps

module tm1638_frame_seq import tm1638_pkg::*; (
    input  logic       clk,
    input  logic       n_rst,
    input  logic       rise_i,
    input  logic       fall_i,
    input  logic       frame_i,
    output byte_kind_t kind_o,
    output logic [4:0] byte_idx_o,
    output logic [2:0] bit_idx_o,
    output logic       shift_o,
    output logic       load_o,
    output logic       sclk_low_o,
    output logic       stb_o,
    output logic       oe_o,
    output logic       read_done_o
);

    // byte map of one frame
    localparam logic [4:0] FIRST_IMAGE = 5'd2;
    localparam logic [4:0] LAST_IMAGE  = 5'(FIRST_IMAGE + IMAGE_BYTES - 1);
    localparam logic [4:0] DISP_ON     = 5'(LAST_IMAGE + 1);
    localparam logic [4:0] READ_CMD    = 5'(DISP_ON + 1);
    localparam logic [4:0] FIRST_READ  = 5'(READ_CMD + 1);
    localparam logic [4:0] LAST_BYTE   = 5'(READ_CMD + NUM_KEY_BYTES);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,   // strobe low, clock not yet running
        ST_BITS,
        ST_GAP      // idle period between bytes
    } state_t;

    state_t state;

    function automatic logic group_start(input logic [4:0] idx);
        return (idx == 5'd0) || (idx == 5'd1) || (idx == DISP_ON) || (idx == READ_CMD);
    endfunction

    function automatic logic group_end(input logic [4:0] idx);
        return (idx == 5'd0) || (idx == LAST_IMAGE) || (idx == DISP_ON) || (idx == LAST_BYTE);
    endfunction

    always_comb begin
        if (byte_idx_o >= FIRST_READ) begin
            kind_o = KIND_READ;
        end else if (byte_idx_o >= FIRST_IMAGE && byte_idx_o <= LAST_IMAGE) begin
            kind_o = KIND_IMAGE;
        end else begin
            kind_o = KIND_CMD;
        end
    end

    assign load_o  = fall_i & ~frame_i
                   & ((state == ST_SETUP) | ((state == ST_GAP) & ~group_start(byte_idx_o)));
    assign shift_o = fall_i & ~frame_i & (state == ST_BITS) & (bit_idx_o != 3'd7);

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state       <= ST_IDLE;
            byte_idx_o  <= '0;
            bit_idx_o   <= '0;
            sclk_low_o  <= 1'b0;
            stb_o       <= 1'b1;
            oe_o        <= 1'b0;
            read_done_o <= 1'b0;
        end else begin
            read_done_o <= 1'b0;
            if (rise_i) begin
                sclk_low_o <= 1'b0;    // board samples here
            end
            if (frame_i) begin         // restarts any running sequence
                state      <= ST_SETUP;
                byte_idx_o <= '0;
                bit_idx_o  <= '0;
                stb_o      <= 1'b0;
                oe_o       <= 1'b1;
            end else if (fall_i) begin
                case (state)
                    ST_SETUP: begin
                        state      <= ST_BITS;
                        bit_idx_o  <= '0;
                        sclk_low_o <= 1'b1;
                    end
                    ST_BITS: begin
                        if (bit_idx_o != 3'd7) begin
                            bit_idx_o  <= bit_idx_o + 1'b1;
                            sclk_low_o <= 1'b1;
                        end else begin
                            if (group_end(byte_idx_o)) begin
                                stb_o <= 1'b1;
                            end
                            if (byte_idx_o == READ_CMD) begin
                                oe_o <= 1'b0;   // hand dio to the board
                            end
                            if (byte_idx_o == LAST_BYTE) begin
                                state       <= ST_IDLE;
                                read_done_o <= 1'b1;
                            end else begin
                                state      <= ST_GAP;
                                byte_idx_o <= byte_idx_o + 1'b1;
                            end
                        end
                    end
                    ST_GAP: begin
                        if (group_start(byte_idx_o)) begin
                            state <= ST_SETUP;
                            stb_o <= 1'b0;
                        end else begin
                            state      <= ST_BITS;
                            bit_idx_o  <= '0;
                            sclk_low_o <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== hdl/tm1638_pkg.sv ====
// shared constants, types and the segment encoder for the TM1638 driver and its testbench
package tm1638_pkg;

    localparam int NUM_DIGITS    = 8;
    localparam int IMAGE_BYTES   = 16;
    localparam int NUM_KEY_BYTES = 4;

    // bus command bytes, one per group
    localparam logic [7:0] CMD_WRITE_AUTO = 8'h40;
    localparam logic [7:0] CMD_ADDR0      = 8'hC0;
    localparam logic [7:0] CMD_DISPLAY_ON = 8'h8F; // on, full brightness
    localparam logic [7:0] CMD_READ_KEYS  = 8'h42;

    // bit 0 is segment a, bit 6 is segment g
    typedef logic [6:0] seg_t;

    typedef struct packed {
        logic [NUM_DIGITS-1:0][3:0] hex;
        seg_t [NUM_DIGITS-1:0]      direct;   // ORed over the hex pattern
        logic [NUM_DIGITS-1:0]      dots;
        logic [NUM_DIGITS-1:0]      leds;
        logic [NUM_DIGITS-1:0]      suppress; // blanks the digit, dot stays
    } disp_in_t;

    typedef enum logic [1:0] {
        KIND_CMD   = 2'd0,
        KIND_IMAGE = 2'd1,
        KIND_READ  = 2'd2
    } byte_kind_t;

    typedef struct packed {
        logic sclk;
        logic stb;
        logic dio;
        logic dio_oe;   // low while the board drives dio
    } tm_bus_t;

    function automatic seg_t seg_encode(input logic [3:0] value);
        seg_t seg;
        case (value)
            //                 gfedcba
            4'h0:    seg = 7'b0111111;
            4'h1:    seg = 7'b0000110;
            4'h2:    seg = 7'b1011011;
            4'h3:    seg = 7'b1001111;
            4'h4:    seg = 7'b1100110;
            4'h5:    seg = 7'b1101101;
            4'h6:    seg = 7'b1111101;
            4'h7:    seg = 7'b0100111;
            4'h8:    seg = 7'b1111111;
            4'h9:    seg = 7'b1101111;
            4'hA:    seg = 7'b1110111;
            4'hB:    seg = 7'b1111100; // lower case b
            4'hC:    seg = 7'b0111001;
            4'hD:    seg = 7'b1011110; // lower case d
            4'hE:    seg = 7'b1111001;
            default: seg = 7'b1110001; // F
        endcase
        return seg;
    endfunction

endpackage

// ==== hdl/tm1638_serial_port.sv ====
// drives the TM1638 pins from the sequencer state, shifts bytes out and gathers the key bits
`timescale 1ns/1ps

module tm1638_serial_port import tm1638_pkg::*; (
    input  logic       clk,
    input  logic       n_rst,
    input  logic       rise_i,
    input  byte_kind_t kind_i,
    input  logic [4:0] byte_idx_i,
    input  logic [2:0] bit_idx_i,
    input  logic       shift_i,
    input  logic       load_i,
    input  logic       sclk_low_i,
    input  logic       stb_i,
    input  logic       oe_i,
    input  logic       read_done_i,
    input  logic [7:0] image_byte_i,
    input  logic       dio_i,
    output tm_bus_t    bus_o,
    output logic [7:0] keys_o
);

    logic [7:0] tx_byte;
    logic [6:0] tx_shift;   // remaining bits, lsb next
    logic       dio_q;
    logic [7:0] key_stage;
    logic       key_sample;
    logic [2:0] key_idx;

    always_comb begin
        tx_byte = 8'h00;    // read bytes keep dio low
        case (kind_i)
            KIND_IMAGE: tx_byte = image_byte_i;
            KIND_CMD: begin
                // commands sit at bytes 0, 1, 18 and 19
                case ({byte_idx_i[4], byte_idx_i[0]})
                    2'b00:   tx_byte = CMD_WRITE_AUTO;
                    2'b01:   tx_byte = CMD_ADDR0;
                    2'b10:   tx_byte = CMD_DISPLAY_ON;
                    default: tx_byte = CMD_READ_KEYS;
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            dio_q <= 1'b0;
        end else if (load_i) begin
            dio_q <= tx_byte[0];
        end else if (shift_i) begin
            dio_q <= tx_shift[0];
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            tx_shift <= tx_byte[7:1];
        end else if (shift_i) begin
            tx_shift <= {1'b0, tx_shift[6:1]};
        end
    end

    // keys sit in bits 0 and 4 of each read byte
    assign key_sample = rise_i & sclk_low_i & (kind_i == KIND_READ) & (bit_idx_i[1:0] == 2'b00);
    assign key_idx    = {~byte_idx_i[1:0], ~bit_idx_i[2]}; // 7 - 2k, or 6 - 2k at bit 4

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            key_stage <= '0;
            keys_o    <= '0;
        end else begin
            if (key_sample) begin
                key_stage[key_idx] <= dio_i;
            end
            if (read_done_i) begin
                keys_o <= key_stage;    // all eight at once
            end
        end
    end

    always_comb begin
        bus_o.sclk   = ~sclk_low_i;
        bus_o.stb    = stb_i;
        bus_o.dio    = dio_q;
        bus_o.dio_oe = oe_i;
    end

endmodule

// ==== hdl/tm1638_tick_gen.sv ====
// divides clk into serial clock edge strobes and the periodic frame request for the driver
`timescale 1ns/1ps

module tm1638_tick_gen #(
    parameter int CLK_HZ   = 8_000_000,
    parameter int SCLK_HZ  = 1_000_000,
    parameter int FRAME_HZ = 2000
) (
    input  logic clk,
    input  logic n_rst,
    output logic rise_o,
    output logic fall_o,
    output logic frame_o
);

    localparam int HALF_DIV    = (CLK_HZ + 2 * SCLK_HZ - 1) / (2 * SCLK_HZ); // rounded up
    localparam int FRAME_TICKS = CLK_HZ / (2 * HALF_DIV * FRAME_HZ);
    localparam int HALF_W      = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;
    localparam int FRAME_W     = (FRAME_TICKS > 1) ? $clog2(FRAME_TICKS) : 1;

    logic [HALF_W-1:0]  half_cnt;
    logic               phase;      // high when the next wrap is a fall
    logic [FRAME_W-1:0] frame_cnt;  // serial periods within a frame
    logic               half_wrap;
    logic               frame_wrap;

    assign half_wrap  = (half_cnt == HALF_W'(HALF_DIV - 1));
    assign frame_wrap = (frame_cnt == FRAME_W'(FRAME_TICKS - 1));

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            half_cnt  <= '0;
            phase     <= 1'b0;
            frame_cnt <= '0;
            rise_o    <= 1'b0;
            fall_o    <= 1'b0;
            frame_o   <= 1'b0;
        end else begin
            rise_o  <= half_wrap & ~phase;
            fall_o  <= half_wrap & phase;
            frame_o <= half_wrap & phase & frame_wrap; // lands on a fall tick
            if (half_wrap) begin
                half_cnt <= '0;
                phase    <= ~phase;
                if (phase) begin
                    frame_cnt <= frame_wrap ? '0 : frame_cnt + 1'b1;
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the TM1638 driver testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tm1638_tb -f files.f -o tm1638_sim > build.log 2>&1 &&
./obj_dir/tm1638_sim > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1
grep -q "TESTS PASSED" sim.log || exit 1
exit 0
